/* common/mul_pkg.sv */
// Assumes OPERAND_WIDTH is a multiple of STEP_BITS and every adder width is a multiple of 4
`default_nettype none

package mul_pkg;

    // Operand and fixed-point format
    localparam int OPERAND_WIDTH = 32;
    localparam int FRAC_BITS     = 8;

    // Radix-4 stepping, two b bits per digit
    localparam int DIGITS_PER_STEP = 4;
    localparam int STEP_BITS       = 2 * DIGITS_PER_STEP;
    localparam int NUM_STEPS       = OPERAND_WIDTH / STEP_BITS;

    // Partial product of a and one digit group
    localparam int PP_WIDTH = OPERAND_WIDTH + STEP_BITS;

    // Holds 3*a plus headroom, rounded up to a whole nibble
    localparam int PP_ADDER_WIDTH = 36;

    typedef logic [OPERAND_WIDTH-1:0]   operand_t;
    typedef logic [2*OPERAND_WIDTH-1:0] product_t;
    typedef logic [PP_WIDTH-1:0]        pp_t;
    typedef logic [STEP_BITS-1:0]       digit_group_t;
    typedef logic [1:0]                 step_count_t;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        FINISH
    } mul_state_e;

endpackage

`default_nettype wire

/* rtl/cla_adder/cla_block_4.sv */
// Pure combinational 4-bit carry-lookahead slice; carries are flattened, no ripple inside
`timescale 1ns/1ns
`default_nettype none

module cla_block_4 (
    input  logic       carry_in,
    input  logic [3:0] a,
    input  logic [3:0] b,
    output logic [3:0] sum,
    output logic       carry_out
);

    logic [3:0] g;
    logic [3:0] p;
    logic [4:0] c;

    assign g = a & b;
    assign p = a ^ b;

    // Lookahead carries, each from carry_in and lower generates
    assign c[0] = carry_in;
    assign c[1] = g[0]
                | (p[0] & carry_in);
    assign c[2] = g[1]
                | (p[1] & g[0])
                | (p[1] & p[0] & carry_in);
    assign c[3] = g[2]
                | (p[2] & g[1])
                | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & carry_in);
    assign c[4] = g[3]
                | (p[3] & g[2])
                | (p[3] & p[2] & g[1])
                | (p[3] & p[2] & p[1] & g[0])
                | (p[3] & p[2] & p[1] & p[0] & carry_in);

    assign sum       = p ^ c[3:0];
    assign carry_out = c[4];

endmodule

`default_nettype wire

/* rtl/cla_adder/cla_adder.sv */
// Unsigned adder of lookahead blocks chained block to block; WIDTH must be a multiple of 4
`timescale 1ns/1ns
`default_nettype none

module cla_adder #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH:0]   sum
);

    // Carry between nibbles, entry 0 is the adder carry-in
    logic [WIDTH/4:0] carry;

    assign carry[0] = 1'b0;

    genvar i;
    generate
        for (i = 0; i < WIDTH / 4; i = i + 1) begin : g_block
            cla_block_4 u_block (
                .carry_in  (carry[i]),
                .a         (a[4*i +: 4]),
                .b         (b[4*i +: 4]),
                .sum       (sum[4*i +: 4]),
                .carry_out (carry[i+1])
            );
        end
    endgenerate

    // Last block carry-out is the top sum bit
    assign sum[WIDTH] = carry[WIDTH/4];

endmodule

`default_nettype wire

/* rtl/radix4_pp_gen.sv */
// Combinational a times one 8-bit group of b, unsigned; result is the full 40-bit partial product
`timescale 1ns/1ns
`default_nettype none

module radix4_pp_gen (
    input  mul_pkg::operand_t     a,
    input  mul_pkg::digit_group_t digits,
    output mul_pkg::pp_t          pp
);

    logic [mul_pkg::PP_ADDER_WIDTH-1:0] a_x1;
    logic [mul_pkg::PP_ADDER_WIDTH-1:0] a_x2;
    logic [mul_pkg::PP_ADDER_WIDTH-1:0] a_x3;
    logic [mul_pkg::PP_ADDER_WIDTH:0]   triple_sum;

    assign a_x1 = {{(mul_pkg::PP_ADDER_WIDTH - mul_pkg::OPERAND_WIDTH){1'b0}}, a};
    assign a_x2 = a_x1 << 1;

    // Triple of a, shared by all digits
    cla_adder #(.WIDTH(mul_pkg::PP_ADDER_WIDTH)) u_triple (
        .a   (a_x1),
        .b   (a_x2),
        .sum (triple_sum)
    );
    assign a_x3 = triple_sum[mul_pkg::PP_ADDER_WIDTH-1:0];

    genvar i;
    generate
        for (i = 0; i < mul_pkg::DIGITS_PER_STEP; i = i + 1) begin : g_digit
            logic [mul_pkg::PP_ADDER_WIDTH-1:0] sel;
            logic [mul_pkg::PP_ADDER_WIDTH-1:0] acc;

            always_comb begin
                case (digits[2*i +: 2])
                    2'd0:    sel = '0;
                    2'd1:    sel = a_x1;
                    2'd2:    sel = a_x2;
                    default: sel = a_x3;
                endcase
            end

            if (i == 0) begin : g_first
                assign acc = sel;
            end else begin : g_chain
                logic [mul_pkg::PP_ADDER_WIDTH:0] acc_sum;

                // Previous total drops its two settled bits
                cla_adder #(.WIDTH(mul_pkg::PP_ADDER_WIDTH)) u_acc (
                    .a   (sel),
                    .b   (g_digit[i-1].acc >> 2),
                    .sum (acc_sum)
                );
                assign acc = acc_sum[mul_pkg::PP_ADDER_WIDTH-1:0];
            end

            if (i < mul_pkg::DIGITS_PER_STEP - 1) begin : g_low
                assign pp[2*i+1:2*i] = acc[1:0];
            end else begin : g_top
                assign pp[mul_pkg::PP_WIDTH-1:2*i] = acc[mul_pkg::PP_WIDTH-2*i-1:0];
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* rtl/radix4_sequencer.sv */
// Fixed schedule of one load, NUM_STEPS steps and one capture; trigger is ignored while busy
`timescale 1ns/1ns
`default_nettype none

module radix4_sequencer (
    input  logic ctl_clk,
    input  logic reset,
    input  logic trigger,
    output logic ready,
    output logic done,
    output logic load,
    output logic step,
    output logic capture
);

    mul_pkg::mul_state_e  state;
    mul_pkg::step_count_t count;

    // Accept only while idle
    assign load    = ready & trigger;
    assign step    = (state == mul_pkg::CALC);
    assign capture = (state == mul_pkg::FINISH);

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state <= mul_pkg::IDLE;
            count <= '0;
            ready <= 1'b1;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                mul_pkg::IDLE: begin
                    if (load) begin
                        state <= mul_pkg::CALC;
                        count <= '0;
                        ready <= 1'b0;
                    end
                end
                mul_pkg::CALC: begin
                    count <= count + 1'b1;
                    if (count == mul_pkg::step_count_t'(mul_pkg::NUM_STEPS - 1)) begin
                        state <= mul_pkg::FINISH;
                    end
                end
                mul_pkg::FINISH: begin
                    // Result lands in y on this edge
                    state <= mul_pkg::IDLE;
                    ready <= 1'b1;
                    done  <= 1'b1;
                end
                default: begin
                    state <= mul_pkg::IDLE;
                    ready <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/radix4_datapath.sv */
// Operands are held from load until the next load; y changes only on capture
`timescale 1ns/1ns
`default_nettype none

module radix4_datapath (
    input  logic              ctl_clk,
    input  logic              reset,
    input  mul_pkg::operand_t a,
    input  mul_pkg::operand_t b,
    input  logic              load,
    input  logic              step,
    input  logic              capture,
    output mul_pkg::operand_t y
);

    mul_pkg::operand_t a_reg;
    mul_pkg::operand_t b_reg;
    mul_pkg::product_t acc;
    mul_pkg::pp_t      pp;
    mul_pkg::pp_t      acc_upper;
    logic [mul_pkg::PP_WIDTH:0] step_sum;

    radix4_pp_gen u_pp_gen (
        .a      (a_reg),
        .digits (b_reg[mul_pkg::STEP_BITS-1:0]),
        .pp     (pp)
    );

    // Upper half of the running product, zero-extended
    assign acc_upper = {{(mul_pkg::PP_WIDTH - mul_pkg::OPERAND_WIDTH){1'b0}},
                        acc[2*mul_pkg::OPERAND_WIDTH-1:mul_pkg::OPERAND_WIDTH]};

    cla_adder #(.WIDTH(mul_pkg::PP_WIDTH)) u_acc_adder (
        .a   (pp),
        .b   (acc_upper),
        .sum (step_sum)
    );

    always_ff @(posedge ctl_clk) begin
        if (load) begin
            a_reg <= a;
            b_reg <= b;
            acc   <= '0;
        end else if (step) begin
            b_reg <= b_reg >> mul_pkg::STEP_BITS;
            // Everything moves down one digit group, new sum enters at the top
            acc[2*mul_pkg::OPERAND_WIDTH-1:mul_pkg::OPERAND_WIDTH-mul_pkg::STEP_BITS]
                <= step_sum[mul_pkg::PP_WIDTH-1:0];
            acc[mul_pkg::OPERAND_WIDTH-mul_pkg::STEP_BITS-1:0]
                <= acc[mul_pkg::OPERAND_WIDTH-1:mul_pkg::STEP_BITS];
        end
    end

    // Fixed-point slice of the finished product
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            y <= '0;
        end else if (capture) begin
            y <= acc[mul_pkg::FRAC_BITS +: mul_pkg::OPERAND_WIDTH];
        end
    end

endmodule

`default_nettype wire

/* rtl/fx_multiplier.sv */
// Unsigned 32x32 multiply returning product bits 39:8; done comes 5 cycles after accept
`timescale 1ns/1ns
`default_nettype none

module fx_multiplier (
    input  logic              ctl_clk,
    input  logic              reset,
    input  mul_pkg::operand_t a,
    input  mul_pkg::operand_t b,
    input  logic              trigger,
    output logic              ready,
    output logic              done,
    output mul_pkg::operand_t y
);

    logic load;
    logic step;
    logic capture;

    radix4_sequencer u_sequencer (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .ready   (ready),
        .done    (done),
        .load    (load),
        .step    (step),
        .capture (capture)
    );

    radix4_datapath u_datapath (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .a       (a),
        .b       (b),
        .load    (load),
        .step    (step),
        .capture (capture),
        .y       (y)
    );

endmodule

`default_nettype wire

/* sim/fx_multiplier_assertions.sv */
// Bound into fx_multiplier; expects trigger held low during reset and operands stable at accept
`timescale 1ns/1ns
`default_nettype none

module fx_multiplier_assertions (
    input logic              ctl_clk,
    input logic              reset,
    input mul_pkg::operand_t a,
    input mul_pkg::operand_t b,
    input logic              trigger,
    input logic              ready,
    input logic              done,
    input mul_pkg::operand_t y
);

    mul_pkg::operand_t expected_y;
    int unsigned       error_count = 0;

    // Unsigned product with the fraction bits dropped
    function automatic mul_pkg::operand_t scaled_product(input mul_pkg::operand_t op_a,
                                                          input mul_pkg::operand_t op_b);
        mul_pkg::product_t full;
        full = mul_pkg::product_t'(op_a) * mul_pkg::product_t'(op_b);
        return full[mul_pkg::FRAC_BITS +: mul_pkg::OPERAND_WIDTH];
    endfunction

    always_ff @(posedge ctl_clk) begin
        if (ready && trigger) begin
            expected_y <= scaled_product(a, b);
        end
    end

    reset_values: assert property (@(posedge ctl_clk)
        $rose(reset) |-> ready && !done && y == '0) else begin
        $error("FAIL reset values: ready %h done %h y %h", ready, done, y);
        error_count++;
    end

    // Done sampled six edges after the accepting edge
    done_latency: assert property (@(posedge ctl_clk) disable iff (!reset)
        $past(ready && trigger, 6) |-> done) else begin
        $error("done missing five cycles after accept");
        error_count++;
    end

    done_cause: assert property (@(posedge ctl_clk) disable iff (!reset)
        done |-> $past(ready && trigger, 6)) else begin
        $error("done without a matching accept");
        error_count++;
    end

    done_single: assert property (@(posedge ctl_clk) disable iff (!reset)
        done |=> !done) else begin
        $error("done lasted more than one cycle");
        error_count++;
    end

    ready_fall: assert property (@(posedge ctl_clk) disable iff (!reset)
        ready && trigger |=> !ready) else begin
        $error("ready stayed high after an accept");
        error_count++;
    end

    ready_rise: assert property (@(posedge ctl_clk) disable iff (!reset)
        $rose(ready) |-> done) else begin
        $error("ready rose before done");
        error_count++;
    end

    y_hold: assert property (@(posedge ctl_clk) disable iff (!reset)
        !done |-> $stable(y)) else begin
        $error("y changed between results");
        error_count++;
    end

    y_result: assert property (@(posedge ctl_clk) disable iff (!reset)
        done |-> y == expected_y) else begin
        $error("FAIL y: expected %h got %h", expected_y, y);
        error_count++;
    end

endmodule

bind fx_multiplier fx_multiplier_assertions u_assertions (
    .ctl_clk (ctl_clk),
    .reset   (reset),
    .a       (a),
    .b       (b),
    .trigger (trigger),
    .ready   (ready),
    .done    (done),
    .y       (y)
);

`default_nettype wire

/* sim/tb_fx_multiplier.sv */
// Needs the bound checker u_assertions; inputs change 1 ns after each rising edge
`timescale 1ns/1ns
`default_nettype none

module tb_fx_multiplier;

    localparam int RESET_CYCLES     = 16;
    localparam int NUM_CORNER       = 6;
    localparam int NUM_RANDOM       = 12;
    localparam int NUM_DISTURB      = 4;
    localparam int NUM_BACK_TO_BACK = 6;
    localparam int NUM_PRODUCTS     = NUM_CORNER + NUM_RANDOM + NUM_DISTURB + NUM_BACK_TO_BACK;
    // Margin covers idle gaps and the wait at each test end
    localparam int TIMEOUT_CYCLES   = NUM_PRODUCTS * 7 + RESET_CYCLES + 64;

    logic              ctl_clk;
    logic              reset;
    mul_pkg::operand_t a;
    mul_pkg::operand_t b;
    logic              trigger;
    logic              ready;
    logic              done;
    mul_pkg::operand_t y;

    integer seed;
    int     cycle_count;
    int     tests_passed;
    int     tests_failed;
    int     test_start_errors;
    int     assertion_errors;

    fx_multiplier u_dut (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .a       (a),
        .b       (b),
        .trigger (trigger),
        .ready   (ready),
        .done    (done),
        .y       (y)
    );

    initial begin
        ctl_clk = 1'b0;
        forever #4 ctl_clk = ~ctl_clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge ctl_clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    task automatic next_cycle();
        @(posedge ctl_clk);
        #1;
    endtask

    task automatic start_test();
        test_start_errors = int'(u_dut.u_assertions.error_count);
    endtask

    task automatic finish_test(input string name);
        int errors;
        // Checker sees the last done pulse and the cycle after it
        repeat (2) next_cycle();
        errors = int'(u_dut.u_assertions.error_count) - test_start_errors;
        if (errors == 0) begin
            tests_passed++;
            $display("test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors);
        end
    endtask

    // One product; disturb scrambles inputs and pulses trigger while busy
    task automatic run_product(input mul_pkg::operand_t op_a, input mul_pkg::operand_t op_b,
                               input bit disturb);
        while (!ready) begin
            next_cycle();
        end
        a       = op_a;
        b       = op_b;
        trigger = 1'b1;
        next_cycle();
        trigger = 1'b0;
        while (!done) begin
            if (disturb) begin
                a       = $random(seed);
                b       = $random(seed);
                trigger = 1'b1;
            end
            next_cycle();
        end
        trigger = 1'b0;
    endtask

    initial begin
        seed         = 32'hb327f940;
        tests_passed = 0;
        tests_failed = 0;
        a            = '0;
        b            = '0;
        trigger      = 1'b0;
        reset        = 1'b0;
        repeat (RESET_CYCLES) @(posedge ctl_clk);
        #1;
        reset = 1'b1;

        start_test();
        finish_test("reset_values");

        // Digit 3 everywhere in b takes the triple of a path
        start_test();
        run_product(32'h0000_0000, 32'h0000_0000, 1'b0);
        run_product(32'h0000_0000, 32'hffff_ffff, 1'b0);
        run_product(32'hffff_ffff, 32'hffff_ffff, 1'b0);
        run_product(32'h1234_5678, 32'hffff_ffff, 1'b0);
        run_product(32'hffff_ffff, 32'h0000_0001, 1'b0);
        run_product(32'h8000_0000, 32'h0000_0100, 1'b0);
        finish_test("corners");

        start_test();
        repeat (NUM_RANDOM) begin
            run_product($random(seed), $random(seed), 1'b0);
            repeat (2) next_cycle();
        end
        finish_test("random_with_gaps");

        start_test();
        repeat (NUM_DISTURB) begin
            run_product($random(seed), $random(seed), 1'b1);
        end
        finish_test("busy_disturbance");

        start_test();
        repeat (NUM_BACK_TO_BACK) begin
            run_product($random(seed), $random(seed), 1'b0);
        end
        finish_test("back_to_back");

        assertion_errors = int'(u_dut.u_assertions.error_count);
        $display("Tests: %0d passed, %0d failed, %0d assertion errors",
                 tests_passed, tests_failed, assertion_errors);
        if (tests_failed == 0 && assertion_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
common/mul_pkg.sv
rtl/cla_adder/cla_block_4.sv
rtl/cla_adder/cla_adder.sv
rtl/radix4_pp_gen.sv
rtl/radix4_sequencer.sv
rtl/radix4_datapath.sv
rtl/fx_multiplier.sv
sim/fx_multiplier_assertions.sv
sim/tb_fx_multiplier.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_fx_multiplier &&
./obj_dir/Vtb_fx_multiplier +verilator+error+limit+1000 \
    | tee /dev/stderr \
    | grep -F -q "Result: PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
